//--- vlog.f
fs_mach_pkg.sv
fs_isa_pkg.sv
fs_stack.sv
fs_exec.sv
fs_host_port.sv
fs_core.sv
tb_clkgen.sv
tb_fs_core.sv

//--- Makefile
# Verilator build, run and lint for the forth execution core

VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_fs_core
RTL_TOP    = fs_core
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
PASS_MSG   = RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# output goes to the terminal and is searched for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		fs_mach_pkg.sv fs_isa_pkg.sv fs_stack.sv fs_exec.sv fs_host_port.sv fs_core.sv
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_fs_core.sv
// ##############################
// testbench for the forth execution core
// host driver, queue model of the stack, random stimulus
// ##############################
`timescale 1ns/1ps

module tb_fs_core;
    import fs_isa_pkg::*;
    import fs_mach_pkg::*;

    localparam int WAIT_LIMIT = 20;   // cycles allowed for each ack edge

    logic       clk;
    logic       rst;
    logic       req;
    fs_cmd_t    cmd_in;
    logic       ack;
    fs_result_t res;

    logic [FS_DSZ-1:0] q[$];          // model stack, q[$] is the top
    logic              exp_err;
    fs_result_t        last_res;      // result of the last handshake
    int                errors;
    int                commands;
    int                test_num;
    int                err_mark;
    string             test_name;
    bit                hung;          // set after a timeout, skips the rest

    fs_opcode_e arith_ops [10] = '{PLUS, MINUS, MUL, AND, OR, XOR, ABS, INVERT, MAX, MIN};
    fs_opcode_e cmp_ops [9]    = '{EQ, GT, LT, NE, GE, LE, ZEQ, ZLT, ZGT};

    tb_clkgen clk_i (.clk(clk));

    fs_core dut_i (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .cmd_in (cmd_in),
        .ack    (ack),
        .result (res)
    );

    function automatic logic [FS_DSZ-1:0] forth_flag(input bit c);
        return c ? 32'hffff_ffff : 32'h0000_0000;   // true is all ones
    endfunction

    // stack items taken by each word, tos included
    function automatic int items_used(input fs_opcode_e op);
        case (op)
            NOP, LIT:                             return 0;
            DUP, DROP, ABS, INVERT, ZEQ, ZLT, ZGT: return 1;
            default:                              return 2;
        endcase
    endfunction

    // stack items left in place of the taken ones
    function automatic int items_left(input fs_opcode_e op);
        case (op)
            NOP, DROP: return 0;
            DUP, SWAP: return 2;
            OVER:      return 3;
            default:   return 1;
        endcase
    endfunction

    // a is the second item, b the top, as in "a b -"
    function automatic logic [FS_DSZ-1:0] word_value(input fs_opcode_e op,
                                                     input logic [FS_DSZ-1:0] a,
                                                     input logic [FS_DSZ-1:0] b);
        logic signed [FS_DSZ-1:0] sa;
        logic signed [FS_DSZ-1:0] sb;
        sa = a;
        sb = b;
        case (op)
            PLUS:    return a + b;
            MINUS:   return a - b;
            MUL:     return a * b;          // low word only
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            ABS:     return (sb < 0) ? 32'd0 - b : b;
            INVERT:  return ~b;
            MAX:     return (sa > sb) ? a : b;
            MIN:     return (sa < sb) ? a : b;
            ZEQ:     return forth_flag(b == 32'd0);
            ZLT:     return forth_flag(sb < 0);
            ZGT:     return forth_flag(sb > 0);
            EQ:      return forth_flag(a == b);
            GT:      return forth_flag(sa > sb);
            LT:      return forth_flag(sa < sb);
            NE:      return forth_flag(a != b);
            GE:      return forth_flag(sa >= sb);
            LE:      return forth_flag(sa <= sb);
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [FS_DSZ-1:0] model_tos();
        return (q.size() > 0) ? q[q.size()-1] : 32'd0;   // empty shows zero
    endfunction

    task automatic model_step(input fs_opcode_e op, input logic [FS_DSZ-1:0] lit);
        int                used;
        int                left;
        logic [FS_DSZ-1:0] a;
        logic [FS_DSZ-1:0] b;
        used = items_used(op);
        left = items_left(op);
        if (used > q.size() || q.size() - used + left > FS_MAX_ITEMS) begin
            exp_err = 1'b1;                 // refused, nothing moves
            return;
        end
        exp_err = 1'b0;
        a = '0;
        b = '0;
        if (used >= 1) b = q.pop_back();
        if (used == 2) a = q.pop_back();
        case (op)
            NOP, DROP: ;
            LIT:  q.push_back(lit);
            DUP: begin
                q.push_back(b);
                q.push_back(b);
            end
            OVER: begin                     // a b -- a b a
                q.push_back(a);
                q.push_back(b);
                q.push_back(a);
            end
            SWAP: begin
                q.push_back(b);
                q.push_back(a);
            end
            default: q.push_back(word_value(op, a, b));
        endcase
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // four-phase handshake, hold = extra cycles req stays up after ack
    task automatic handshake(input fs_cmd_t c, input int hold, output bit ok);
        int waited;
        ok = 1'b0;
        if (hung) return;
        @(posedge clk);
        cmd_in <= c;
        req    <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ack !== 1'b1 && waited < WAIT_LIMIT);
        if (ack !== 1'b1) begin
            $display("timeout: ack did not rise within %0d cycles", WAIT_LIMIT);
            errors++;
            hung = 1'b1;
            return;
        end
        check("ack_latency", waited, 3);    // sampled next edge, ack two edges later
        last_res = res;
        repeat (hold) @(posedge clk);
        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ack !== 1'b0 && waited < WAIT_LIMIT);
        if (ack !== 1'b0) begin
            $display("timeout: ack did not fall within %0d cycles", WAIT_LIMIT);
            errors++;
            hung = 1'b1;
            return;
        end
        ok = 1'b1;
    endtask

    task automatic run_cmd(input fs_opcode_e op, input logic [FS_DSZ-1:0] lit, input int hold);
        fs_cmd_t c;
        bit      ok;
        c.op  = op;
        c.lit = lit;
        handshake(c, hold, ok);
        if (!ok) return;
        model_step(op, lit);
        commands++;
        check("tos", last_res.tos, model_tos());
        check("depth", 32'(last_res.depth), q.size());
        check("err", 32'(last_res.err), 32'(exp_err));
    endtask

    task automatic drain();
        while (q.size() > 0 && !hung) run_cmd(DROP, 32'd0, 0);
    endtask

    // mostly full range, sometimes small values of both signs
    function automatic logic [FS_DSZ-1:0] rand_word();
        logic [FS_DSZ-1:0] w;
        if ($urandom_range(3, 0) == 0) w = 32'($urandom_range(16, 0)) - 32'd8;
        else w = $urandom();
        return w;
    endfunction

    task automatic start_test(input string name);
        test_num++;
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        $display("test %0d %s: %s, %0d errors", test_num, test_name,
                 (errors == err_mark && !hung) ? "ok" : "failed", errors - err_mark);
    endtask

    initial begin
        logic [FS_DSZ-1:0] a;
        fs_opcode_e        op;
        rst    = 1'b1;
        req    = 1'b0;
        cmd_in = '0;
        void'($urandom(8));
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        start_test("reset nop");
        run_cmd(NOP, 32'd0, 0);
        end_test();

        start_test("stack words");
        run_cmd(LIT, 32'h11, 0);
        run_cmd(LIT, 32'h22, 0);
        run_cmd(LIT, 32'h33, 1);
        run_cmd(DUP, 32'd0, 0);
        run_cmd(DROP, 32'd0, 0);
        run_cmd(OVER, 32'd0, 0);   // 11 22 33 22
        run_cmd(SWAP, 32'd0, 2);
        run_cmd(OVER, 32'd0, 0);
        drain();
        end_test();

        start_test("arithmetic");
        run_cmd(LIT, 32'hffff_fffb, 0);      // abs of -5
        run_cmd(ABS, 32'd0, 0);
        run_cmd(LIT, 32'hffff_fffd, 0);      // max and min of -3 and -7
        run_cmd(LIT, 32'hffff_fff9, 0);
        run_cmd(MAX, 32'd0, 0);
        run_cmd(LIT, 32'hffff_fff9, 0);
        run_cmd(MIN, 32'd0, 0);
        repeat (60) begin
            if (q.size() > 12) drain();
            run_cmd(LIT, rand_word(), 0);
            run_cmd(LIT, rand_word(), 0);
            run_cmd(arith_ops[$urandom_range(9, 0)], 32'd0, 0);
        end
        drain();
        end_test();

        start_test("comparisons");
        repeat (60) begin
            if (q.size() > 12) drain();
            a = rand_word();
            run_cmd(LIT, a, 0);
            run_cmd(LIT, ($urandom_range(3, 0) == 0) ? a : rand_word(), 0);
            run_cmd(cmp_ops[$urandom_range(8, 0)], 32'd0, 0);
            if (!hung && last_res.tos !== 32'h0 && last_res.tos !== 32'hffff_ffff) begin
                $display("comparison left a value that is neither true nor false");
                errors++;
            end
        end
        drain();
        end_test();

        start_test("underflow and overflow");
        run_cmd(DROP, 32'd0, 0);             // every one of these needs items
        run_cmd(DUP, 32'd0, 0);
        run_cmd(SWAP, 32'd0, 0);
        run_cmd(ABS, 32'd0, 0);
        run_cmd(LIT, 32'd5, 0);
        run_cmd(PLUS, 32'd0, 0);             // one item, binary word refused
        run_cmd(NOP, 32'd0, 0);
        drain();
        repeat (18) run_cmd(LIT, rand_word(), 0);
        check("err", 32'(last_res.err), 32'd1);
        check("depth", 32'(last_res.depth), 32'd17);
        run_cmd(DUP, 32'd0, 0);              // full, dup refused too
        run_cmd(NOP, 32'd0, 0);
        drain();
        end_test();

        start_test("random mix");
        repeat (300) begin
            if ($urandom_range(9, 0) < 3) op = LIT;
            else op = fs_opcode_e'(5'($urandom_range(24, 0)));
            repeat ($urandom_range(2, 0)) @(posedge clk);   // idle gap
            run_cmd(op, rand_word(), $urandom_range(3, 0));
        end
        end_test();

        $display("tests %0d, commands %0d, errors %0d", test_num, commands, errors);
        if (errors == 0 && !hung) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb_clkgen.sv
// ##############################
// testbench clock source
// free-running clk, 40 ns period
// ##############################
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk
);
    initial clk = 1'b0;

    always #20 clk = ~clk;   // half period of 20 ns

endmodule

//--- fs_core.sv
// ##############################
// forth execution core top level
// host port, execution unit and data stack
// ##############################
`timescale 1ns/1ps

module fs_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  fs_isa_pkg::fs_cmd_t     cmd_in,
    output logic                    ack,
    output fs_mach_pkg::fs_result_t result
);
    import fs_isa_pkg::*;
    import fs_mach_pkg::*;

    logic                go;
    fs_cmd_t             cmd;     // latched command
    fs_sreq_t            sreq;
    logic [FS_DSZ-1:0]   nos;
    logic [FS_CNT_W-1:0] count;

    fs_host_port port_i (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .cmd_in (cmd_in),
        .ack    (ack),
        .go     (go),
        .cmd    (cmd)
    );

    fs_exec exec_i (
        .clk    (clk),
        .rst    (rst),
        .go     (go),
        .cmd    (cmd),
        .nos    (nos),
        .count  (count),
        .sreq   (sreq),
        .result (result)
    );

    fs_stack stack_i (
        .clk    (clk),
        .rst    (rst),
        .sreq   (sreq),
        .nos    (nos),
        .count  (count)
    );

endmodule

//--- fs_host_port.sv
// ##############################
// host command port
// four-phase req/ack, one execution per command
// ##############################
`timescale 1ns/1ps

module fs_host_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  fs_isa_pkg::fs_cmd_t cmd_in,
    output logic                ack,
    output logic                go,      // one-cycle start to the execution unit
    output fs_isa_pkg::fs_cmd_t cmd      // latched copy, stable through exec and ack
);
    import fs_isa_pkg::*;

    typedef enum logic [1:0] {
        IDLE,    // waiting for req
        EXEC,    // go is high, exec commits at the next edge
        ACK      // result valid, wait for req to drop
    } state_e;

    state_e state;
    logic   accept;

    assign accept = (state == IDLE) && req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            go    <= 1'b0;
            ack   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= EXEC;
                        go    <= 1'b1;
                    end
                end
                EXEC: begin
                    state <= ACK;
                    go    <= 1'b0;
                    ack   <= 1'b1;    // tos and depth committed on this edge
                end
                ACK: begin
                    if (!req) begin      // slow host just parks us here
                        state <= IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // command register, captured with the accepting edge
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd <= cmd_in;
        end
    end

    a_go_not_in_ack: assert property (
        @(posedge clk) disable iff (rst)
        $rose(go) |-> !ack
    ) else $error("go raised while ack is high");

endmodule

//--- fs_exec.sv
// ##############################
// execution unit
// tos register, depth rules, stack and alu words
// ##############################
`timescale 1ns/1ps

module fs_exec (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             go,       // one-cycle start from the port
    input  fs_isa_pkg::fs_cmd_t              cmd,
    input  logic [fs_mach_pkg::FS_DSZ-1:0]   nos,
    input  logic [fs_mach_pkg::FS_CNT_W-1:0] count,
    output fs_mach_pkg::fs_sreq_t            sreq,
    output fs_mach_pkg::fs_result_t          result
);
    import fs_isa_pkg::*;
    import fs_mach_pkg::*;

    logic [FS_DSZ-1:0]        tos;          // top of stack register
    logic                     tos_vld;      // tos holds an item
    logic                     err;
    logic [FS_DSZ-1:0]        tos_n;
    logic                     tos_vld_n;
    logic [FS_CNT_W-1:0]      depth;
    logic [1:0]               n_pop;
    logic [1:0]               n_push;
    int                       new_depth;
    logic                     refuse;
    logic                     binary;       // two in, one out
    logic signed [FS_DSZ-1:0] s_tos;
    logic signed [FS_DSZ-1:0] s_nos;
    fs_sreq_t                 sreq_n;

    // forth truth, all ones or zero
    function automatic logic [FS_DSZ-1:0] flag(input logic c);
        return {FS_DSZ{c}};
    endfunction

    assign depth = count + FS_CNT_W'(tos_vld);
    assign s_tos = tos;
    assign s_nos = nos;

    // stack effect of the current opcode
    assign n_pop     = fs_pops(cmd.op);
    assign n_push    = fs_pushes(cmd.op);
    assign binary    = (n_pop == 2'd2) && (n_push == 2'd1);
    assign new_depth = int'(depth) - int'(n_pop) + int'(n_push);
    assign tos_vld_n = (new_depth != 0);

    // underflow or overflow, machine state stays put
    assign refuse = (int'(n_pop) > int'(depth)) || (new_depth > FS_MAX_ITEMS);

    always_comb begin
        tos_n       = tos;
        sreq_n.op   = SOP_NONE;
        sreq_n.data = tos;                  // every push or replace stores the old tos
        case (cmd.op)
            LIT: begin
                tos_n = cmd.lit;
                if (tos_vld) begin           // nothing to spill on an empty stack
                    sreq_n.op = SOP_PUSH;
                end
            end
            DUP:    sreq_n.op = SOP_PUSH;
            DROP: begin
                if (count != '0) begin
                    tos_n     = nos;
                    sreq_n.op = SOP_POP;
                end
            end
            OVER: begin
                tos_n     = nos;
                sreq_n.op = SOP_PUSH;
            end
            SWAP: begin
                tos_n     = nos;
                sreq_n.op = SOP_REPLACE;
            end
            PLUS:   tos_n = nos + tos;
            MINUS:  tos_n = nos - tos;
            MUL:    tos_n = nos * tos;      // low word of the product
            AND:    tos_n = nos & tos;
            OR:     tos_n = nos | tos;
            XOR:    tos_n = nos ^ tos;
            ABS:    tos_n = (s_tos < 0) ? -tos : tos;
            INVERT: tos_n = ~tos;
            MAX:    tos_n = (s_nos > s_tos) ? nos : tos;
            MIN:    tos_n = (s_nos < s_tos) ? nos : tos;
            ZEQ:    tos_n = flag(tos == '0);
            ZLT:    tos_n = flag(s_tos < 0);
            ZGT:    tos_n = flag(s_tos > 0);
            // second operand is nos, as in "a b <"
            EQ:     tos_n = flag(nos == tos);
            GT:     tos_n = flag(s_nos > s_tos);
            LT:     tos_n = flag(s_nos < s_tos);
            NE:     tos_n = flag(nos != tos);
            GE:     tos_n = flag(s_nos >= s_tos);
            LE:     tos_n = flag(s_nos <= s_tos);
            default: ;                       // nop
        endcase
        if (binary) begin
            sreq_n.op = SOP_POP;             // nos folded into tos
        end
    end

    // only a legal command in its go cycle touches the stack
    always_comb begin
        sreq = sreq_n;
        if (!go || refuse) begin
            sreq.op = SOP_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tos     <= '0;
            tos_vld <= 1'b0;
            err     <= 1'b0;
        end else if (go) begin
            err <= refuse;                   // nop is always legal, so it clears err
            if (!refuse) begin
                tos     <= tos_vld_n ? tos_n : '0;   // empty stack shows zero
                tos_vld <= tos_vld_n;
            end
        end
    end

    assign result.tos   = tos;
    assign result.depth = depth;
    assign result.err   = err;

    // items below the top only exist while the tos register holds one
    a_tos_backs_stack: assert property (
        @(posedge clk) disable iff (rst)
        (count != '0) |-> tos_vld
    ) else $error("stack block holds items while tos is empty");

endmodule

//--- fs_stack.sv
// ##############################
// data stack below the tos register
// register file with push, pop and replace
// ##############################
`timescale 1ns/1ps

module fs_stack (
    input  logic                             clk,
    input  logic                             rst,
    input  fs_mach_pkg::fs_sreq_t            sreq,
    output logic [fs_mach_pkg::FS_DSZ-1:0]   nos,    // entry at count - 1
    output logic [fs_mach_pkg::FS_CNT_W-1:0] count
);
    import fs_mach_pkg::*;

    logic [FS_DSZ-1:0]           mem [FS_DEPTH];   // payload, no reset
    logic [$clog2(FS_DEPTH)-1:0] top_idx;          // slot of the entry just below tos
    logic [$clog2(FS_DEPTH)-1:0] wr_idx;

    // wraps to the last slot when empty, nos is a don't care then
    assign top_idx = count[$clog2(FS_DEPTH)-1:0] - 1'b1;
    assign nos     = mem[top_idx];                  // zero-cycle read

    // push goes one above the current top, replace hits the top itself
    assign wr_idx = (sreq.op == SOP_PUSH) ? count[$clog2(FS_DEPTH)-1:0] : top_idx;

    always_ff @(posedge clk) begin
        if (sreq.op == SOP_PUSH || sreq.op == SOP_REPLACE) begin
            mem[wr_idx] <= sreq.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case (sreq.op)
                SOP_PUSH: count <= count + 1'b1;
                SOP_POP:  count <= count - 1'b1;
                default:  ;                         // none and replace keep the count
            endcase
        end
    end

    // the execution unit's depth check must keep us inside the file
    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        (sreq.op == SOP_POP || sreq.op == SOP_REPLACE) |-> (count != '0)
    ) else $error("stack pop or replace while empty");

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        (sreq.op == SOP_PUSH) |-> (count < FS_CNT_W'(FS_DEPTH))
    ) else $error("stack push while full");

endmodule

//--- fs_isa_pkg.sv
// ##############################
// forth core instruction set
// opcodes, command word and stack-effect rules
// ##############################
package fs_isa_pkg;

    localparam int FS_OP_W = 5;   // opcode field width

    typedef enum logic [FS_OP_W-1:0] {
        NOP, LIT,                          // control and literal push
        DUP, DROP, OVER, SWAP,             // stack words
        PLUS, MINUS, MUL, AND, OR, XOR,    // binary arithmetic and bitwise
        ABS, INVERT,                       // unary
        MAX, MIN,                          // signed select
        ZEQ, ZLT, ZGT,                     // compare against zero
        EQ, GT, LT, NE, GE, LE             // two-operand compares, signed
    } fs_opcode_e;

    // one host command, 37 bits
    typedef struct packed {
        fs_opcode_e                     op;
        logic [fs_mach_pkg::FS_DSZ-1:0] lit;   // only used by LIT
    } fs_cmd_t;

    // items an opcode consumes from the stack (tos counts as one)
    function automatic logic [1:0] fs_pops(input fs_opcode_e op);
        case (op)
            NOP, LIT:                           return 2'd0;
            DUP, DROP, ABS, INVERT:             return 2'd1;
            ZEQ, ZLT, ZGT:                      return 2'd1;
            default:                            return 2'd2;   // over, swap and all binary words
        endcase
    endfunction

    // items an opcode leaves behind in place of the ones it consumed
    function automatic logic [1:0] fs_pushes(input fs_opcode_e op);
        case (op)
            NOP, DROP:                          return 2'd0;
            DUP, SWAP:                          return 2'd2;
            OVER:                               return 2'd3;
            default:                            return 2'd1;   // lit, unary and binary words
        endcase
    endfunction

endpackage

//--- fs_mach_pkg.sv
// ##############################
// forth core machine package
// data path sizes, stack requests and the result word
// ##############################
package fs_mach_pkg;

    localparam int FS_DSZ       = 32;             // data word width
    localparam int FS_DEPTH     = 16;             // entries below the top of stack
    localparam int FS_CNT_W     = 5;              // depth counter width
    localparam int FS_MAX_ITEMS = FS_DEPTH + 1;   // stack block plus the tos register

    // what the stack block does at the next edge
    typedef enum logic [1:0] {
        SOP_NONE    = 2'd0,
        SOP_PUSH    = 2'd1,   // write at count, count + 1
        SOP_POP     = 2'd2,   // count - 1, data ignored
        SOP_REPLACE = 2'd3    // overwrite the entry at count - 1
    } fs_sop_e;

    // request from the execution unit to the stack, 34 bits
    typedef struct packed {
        fs_sop_e           op;
        logic [FS_DSZ-1:0] data;
    } fs_sreq_t;

    // state seen by the host after each command, 38 bits
    typedef struct packed {
        logic [FS_DSZ-1:0]   tos;    // top of stack, zero when empty
        logic [FS_CNT_W-1:0] depth;  // items including the tos register
        logic                err;    // last command was refused
    } fs_result_t;

endpackage
